// File: logic/controlUnit.sv
`default_nettype none

module controlUnit (
    input  wire  Clock,
    input  wire  rstN,
    input  wire  memDone,
    input  wire  aluDone,
    input  wire  isLoad,
    input  wire  isStore,
    input  wire  isJal,
    input  wire  isBranch,
    input  wire  aluCond,
    output logic fetchReq,
    output logic decodeEn,
    output logic aluStart,
    output logic regWrite,
    output logic loadReq,
    output logic storeReq,
    output logic pcUpdate,
    output logic pcJump
);

    cpuPkg::ctrlStateT state;
    cpuPkg::ctrlStateT nextState;
    cpuPkg::ctrlStateT wbState;

    // writeback path, taken once the ALU is done
    always_comb begin
        if (isJal || isBranch) begin
            wbState = cpuPkg::stWbJump;
        end else if (isStore) begin
            wbState = cpuPkg::stWbStore;
        end else if (isLoad) begin
            wbState = cpuPkg::stWbLoad;
        end else begin
            wbState = cpuPkg::stWbDefault;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            cpuPkg::stFetch: begin
                if (memDone) begin
                    nextState = cpuPkg::stDecode;
                end
            end
            cpuPkg::stDecode: nextState = cpuPkg::stAlu1;
            cpuPkg::stAlu1,
            cpuPkg::stAlu: nextState = aluDone ? wbState : cpuPkg::stAlu;
            cpuPkg::stWbJump: nextState = cpuPkg::stFetch;
            cpuPkg::stWbStore: begin
                if (memDone) begin
                    nextState = cpuPkg::stFetch;
                end
            end
            cpuPkg::stWbLoad: begin
                if (memDone) begin
                    nextState = cpuPkg::stWbDefault;
                end
            end
            cpuPkg::stWbDefault: nextState = cpuPkg::stFetch;
            default: nextState = cpuPkg::stFetch;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state <= cpuPkg::stFetch;
        end else begin
            state <= nextState;
        end
    end

    assign fetchReq = state == cpuPkg::stFetch;
    assign decodeEn = state == cpuPkg::stDecode;
    assign aluStart = state == cpuPkg::stAlu1;
    assign loadReq  = state == cpuPkg::stWbLoad;
    assign storeReq = state == cpuPkg::stWbStore;

    // link write for JAL happens while the PC still points at the JAL
    assign regWrite = ((state == cpuPkg::stAlu1 || state == cpuPkg::stAlu) && isJal)
                      || state == cpuPkg::stWbDefault;

    // PC moves once, on the last cycle of each writeback path
    assign pcUpdate = state == cpuPkg::stWbJump || state == cpuPkg::stWbDefault
                      || (state == cpuPkg::stWbStore && memDone);

    assign pcJump = isJal || (isBranch && aluCond);

    // bus done only while a transfer is awaited
    assert property (@(posedge Clock) disable iff (!rstN)
                     memDone |-> (fetchReq || loadReq || storeReq));

endmodule

`default_nettype wire

// File: logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // ====================
    // widths
    // ====================
    typedef logic [31:0] wordT;
    typedef logic [31:0] addrT;
    typedef logic [4:0]  regIdxT;
    typedef logic [31:0] instrT;
    typedef logic [6:0]  opcodeT;

    // major opcodes of the supported subset
    localparam opcodeT opOpImm  = 7'b0010011;
    localparam opcodeT opOp     = 7'b0110011;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opJal    = 7'b1101111;

    // first fetch after reset
    localparam addrT resetPc = 32'h0000_0000;

    // ====================
    // enums
    // ====================
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSll,
        aluSrl,
        aluCmpEq
    } aluOpT;

    typedef enum logic [2:0] {
        stFetch     = 3'd0,
        stDecode    = 3'd1,
        stAlu1      = 3'd2,
        stAlu       = 3'd3,
        stWbJump    = 3'd4,
        stWbStore   = 3'd5,
        stWbLoad    = 3'd6,
        stWbDefault = 3'd7
    } ctrlStateT;

endpackage

`default_nettype wire

// File: logic/fetchUnit.sv
`default_nettype none

module fetchUnit (
    input  wire                Clock,
    input  wire                rstN,
    input  wire                loadInstr,
    input  wire cpuPkg::instrT newInstr,
    input  wire                pcUpdate,
    input  wire                pcJump,
    input  wire cpuPkg::wordT  imm,
    output cpuPkg::addrT       pc,
    output cpuPkg::instrT      instr,
    output cpuPkg::wordT       linkAddr
);

    cpuPkg::addrT target;

    // branch and JAL target, pc relative
    assign target   = pc + imm;
    assign linkAddr = pc + 32'd4;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pc <= cpuPkg::resetPc;
        end else if (pcUpdate) begin
            pc <= pcJump ? target : linkAddr;
        end
    end

    // cleared so no class flag is set before the first fetch
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            instr <= '0;
        end else if (loadInstr) begin
            instr <= newInstr;
        end
    end

endmodule

`default_nettype wire

// File: logic/instrDecoder.sv
`default_nettype none

module instrDecoder (
    input  wire cpuPkg::instrT instr,
    output cpuPkg::regIdxT     rs1,
    output cpuPkg::regIdxT     rs2,
    output cpuPkg::regIdxT     rd,
    output cpuPkg::wordT       imm,
    output cpuPkg::aluOpT      aluOp,
    output logic               useImm,
    output logic               isLoad,
    output logic               isStore,
    output logic               isJal,
    output logic               isBranch,
    output logic               branchNe
);

    cpuPkg::opcodeT opcode;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    assign isLoad   = opcode == cpuPkg::opLoad;
    assign isStore  = opcode == cpuPkg::opStore;
    assign isJal    = opcode == cpuPkg::opJal;
    assign isBranch = opcode == cpuPkg::opBranch;
    assign branchNe = isBranch && funct3[0];
    assign useImm   = opcode == cpuPkg::opOpImm || isLoad || isStore || isJal;

    // sign extended immediates, I type by default
    always_comb begin
        case (opcode)
            cpuPkg::opStore:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            cpuPkg::opBranch: imm = {{19{instr[31]}}, instr[31], instr[7],
                                     instr[30:25], instr[11:8], 1'b0};
            cpuPkg::opJal:    imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                     instr[20], instr[30:21], 1'b0};
            default:          imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    // loads, stores, ADDI and JAL all add
    always_comb begin
        aluOp = cpuPkg::aluAdd;
        if (opcode == cpuPkg::opOp) begin
            case (funct3)
                3'b000: begin
                    if (instr[30]) begin
                        aluOp = cpuPkg::aluSub;
                    end
                end
                3'b001:  aluOp = cpuPkg::aluSll;
                3'b100:  aluOp = cpuPkg::aluXor;
                3'b101:  aluOp = cpuPkg::aluSrl;
                3'b110:  aluOp = cpuPkg::aluOr;
                3'b111:  aluOp = cpuPkg::aluAnd;
                default: aluOp = cpuPkg::aluAdd;
            endcase
        end else if (isBranch) begin
            aluOp = cpuPkg::aluCmpEq;
        end
    end

endmodule

`default_nettype wire

// File: logic/memPort.sv
`default_nettype none

module memPort (
    input  wire               Clock,
    input  wire               rstN,
    input  wire               fetchReq,
    input  wire               loadReq,
    input  wire               storeReq,
    input  wire cpuPkg::addrT pc,
    input  wire cpuPkg::addrT dataAddr,
    input  wire cpuPkg::wordT storeData,
    input  wire               memAck,
    input  wire cpuPkg::wordT memRdata,
    output logic              memReq,
    output logic              memWe,
    output cpuPkg::addrT      memAddr,
    output cpuPkg::wordT      memWdata,
    output cpuPkg::wordT      rdata,
    output logic              done
);

    typedef enum logic [1:0] {
        portIdle,
        portRequest,
        portRelease
    } portStateT;

    portStateT state;
    logic [2:0] reqNow;
    logic [2:0] reqPrev;
    logic startXfer;

    // one transfer per rising request level
    assign reqNow    = {storeReq, loadReq, fetchReq};
    assign startXfer = state == portIdle && |(reqNow & ~reqPrev);

    // ====================
    // handshake FSM
    // ====================
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state   <= portIdle;
            reqPrev <= 3'b000;
            memReq  <= 1'b0;
            memWe   <= 1'b0;
            done    <= 1'b0;
        end else begin
            reqPrev <= reqNow;
            done    <= 1'b0;
            case (state)
                portIdle: begin
                    if (startXfer) begin
                        memReq <= 1'b1;
                        memWe  <= storeReq;
                        state  <= portRequest;
                    end
                end
                portRequest: begin
                    if (memAck) begin
                        memReq <= 1'b0;
                        state  <= portRelease;
                    end
                end
                portRelease: begin
                    if (!memAck) begin
                        done  <= 1'b1;
                        state <= portIdle;
                    end
                end
                default: state <= portIdle;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (startXfer) begin
            memAddr  <= fetchReq ? pc : dataAddr;
            memWdata <= storeData;
        end
        if (state == portRequest && memAck) begin
            rdata <= memRdata;
        end
    end

    // memory acks only a pending request
    assert property (@(posedge Clock) disable iff (!rstN) $rose(memAck) |-> memReq);

endmodule

`default_nettype wire

// File: logic/regFile.sv
`default_nettype none

module regFile (
    input  wire                 Clock,
    input  wire                 rstN,
    input  wire cpuPkg::regIdxT rs1,
    input  wire cpuPkg::regIdxT rs2,
    input  wire cpuPkg::regIdxT rd,
    input  wire                 we,
    input  wire cpuPkg::wordT   wdata,
    output cpuPkg::wordT        rdata1,
    output cpuPkg::wordT        rdata2
);

    cpuPkg::wordT regs [32];

    // x0 is cleared at reset and never written
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

`default_nettype wire

// File: logic/riscCore.sv
`default_nettype none

module riscCore (
    input  wire               Clock,
    input  wire               rstN,
    output wire               memReq,
    output wire               memWe,
    output wire cpuPkg::addrT memAddr,
    output wire cpuPkg::wordT memWdata,
    input  wire               memAck,
    input  wire cpuPkg::wordT memRdata
);

    logic fetchReq;
    logic aluStart;
    logic regWrite;
    logic loadReq;
    logic storeReq;
    logic pcUpdate;
    logic pcJump;
    logic memDone;
    logic aluDone;
    logic aluCond;
    logic loadInstr;
    logic useImm;
    logic isLoad;
    logic isStore;
    logic isJal;
    logic isBranch;
    logic branchNe;
    cpuPkg::regIdxT rs1;
    cpuPkg::regIdxT rs2;
    cpuPkg::regIdxT rd;
    cpuPkg::wordT imm;
    cpuPkg::aluOpT aluOp;
    cpuPkg::addrT pc;
    cpuPkg::instrT instr;
    cpuPkg::wordT linkAddr;
    cpuPkg::wordT rdata1;
    cpuPkg::wordT rdata2;
    cpuPkg::wordT aluB;
    cpuPkg::wordT aluResult;
    cpuPkg::wordT loadData;
    cpuPkg::wordT regWdata;

    // operand and writeback selects
    assign loadInstr = memDone && fetchReq;
    assign aluB      = useImm ? imm : rdata2;
    assign regWdata  = isJal ? linkAddr : (isLoad ? loadData : aluResult);

    controlUnit ctrl0 (
        .Clock(Clock),
        .rstN(rstN),
        .memDone(memDone),
        .aluDone(aluDone),
        .isLoad(isLoad),
        .isStore(isStore),
        .isJal(isJal),
        .isBranch(isBranch),
        .aluCond(aluCond),
        .fetchReq(fetchReq),
        .decodeEn(),
        .aluStart(aluStart),
        .regWrite(regWrite),
        .loadReq(loadReq),
        .storeReq(storeReq),
        .pcUpdate(pcUpdate),
        .pcJump(pcJump)
    );

    instrDecoder decoder0 (
        .instr(instr),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .imm(imm),
        .aluOp(aluOp),
        .useImm(useImm),
        .isLoad(isLoad),
        .isStore(isStore),
        .isJal(isJal),
        .isBranch(isBranch),
        .branchNe(branchNe)
    );

    seqAlu alu0 (
        .Clock(Clock),
        .rstN(rstN),
        .start(aluStart),
        .op(aluOp),
        .a(rdata1),
        .b(aluB),
        .branchNe(branchNe),
        .result(aluResult),
        .done(aluDone),
        .cond(aluCond)
    );

    regFile regs0 (
        .Clock(Clock),
        .rstN(rstN),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .we(regWrite),
        .wdata(regWdata),
        .rdata1(rdata1),
        .rdata2(rdata2)
    );

    fetchUnit fetch0 (
        .Clock(Clock),
        .rstN(rstN),
        .loadInstr(loadInstr),
        .newInstr(loadData),
        .pcUpdate(pcUpdate),
        .pcJump(pcJump),
        .imm(imm),
        .pc(pc),
        .instr(instr),
        .linkAddr(linkAddr)
    );

    memPort port0 (
        .Clock(Clock),
        .rstN(rstN),
        .fetchReq(fetchReq),
        .loadReq(loadReq),
        .storeReq(storeReq),
        .pc(pc),
        .dataAddr(aluResult),
        .storeData(rdata2),
        .memAck(memAck),
        .memRdata(memRdata),
        .memReq(memReq),
        .memWe(memWe),
        .memAddr(memAddr),
        .memWdata(memWdata),
        .rdata(loadData),
        .done(memDone)
    );

endmodule

`default_nettype wire

// File: logic/seqAlu.sv
`default_nettype none

module seqAlu (
    input  wire                Clock,
    input  wire                rstN,
    input  wire                start,
    input  wire cpuPkg::aluOpT op,
    input  wire cpuPkg::wordT  a,
    input  wire cpuPkg::wordT  b,
    input  wire                branchNe,
    output cpuPkg::wordT       result,
    output logic               done,
    output logic               cond
);

    logic [4:0] count;
    cpuPkg::wordT acc;
    cpuPkg::wordT quickResult;
    cpuPkg::wordT firstStep;
    cpuPkg::wordT startValue;
    logic condReg;
    logic equal;
    logic isShift;
    logic longShift;

    assign equal     = a == b;
    assign isShift   = op == cpuPkg::aluSll || op == cpuPkg::aluSrl;
    assign longShift = isShift && b[4:0] != 5'd0;

    // single cycle ops, a shift by zero passes a through
    always_comb begin
        case (op)
            cpuPkg::aluAdd:   quickResult = a + b;
            cpuPkg::aluSub:   quickResult = a - b;
            cpuPkg::aluAnd:   quickResult = a & b;
            cpuPkg::aluOr:    quickResult = a | b;
            cpuPkg::aluXor:   quickResult = a ^ b;
            cpuPkg::aluCmpEq: quickResult = {31'd0, equal};
            default:          quickResult = a;
        endcase
    end

    // first shift step already happens in the start cycle
    assign firstStep  = (op == cpuPkg::aluSll) ? a << 1 : a >> 1;
    assign startValue = longShift ? firstStep : quickResult;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            count <= 5'd0;
        end else if (start && longShift) begin
            count <= b[4:0] - 5'd1;
        end else if (count != 5'd0) begin
            count <= count - 5'd1;
        end
    end

    always_ff @(posedge Clock) begin
        if (start) begin
            acc     <= startValue;
            condReg <= equal ^ branchNe;
        end else if (count != 5'd0) begin
            acc <= (op == cpuPkg::aluSll) ? acc << 1 : acc >> 1;
        end
    end

    assign result = start ? startValue : acc;
    assign done   = start ? !longShift : count == 5'd0;
    assign cond   = start ? equal ^ branchNe : condReg;

    // controller must wait for a running shift
    assert property (@(posedge Clock) disable iff (!rstN) start |-> count == 5'd0);

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module coreTb -f src.f -o coreSim

./obj_dir/coreSim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: src.f
logic/cpuPkg.sv
logic/controlUnit.sv
logic/instrDecoder.sv
logic/seqAlu.sv
logic/regFile.sv
logic/fetchUnit.sv
logic/memPort.sv
logic/riscCore.sv
tests/clockGen.sv
tests/coreTb.sv

// File: tests/clockGen.sv
`default_nettype none

module clockGen (
    output logic Clock,
    output logic rstN
);

    timeunit 1ns;
    timeprecision 100ps;

    // 20 ns period
    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    // reset held low for 8 rising edges
    initial begin
        rstN = 1'b0;
        repeat (8) @(posedge Clock);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/coreTb.sv
`default_nettype none

module coreTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int memWords = 256;
    localparam int kindFetch = 0;
    localparam int kindLoad = 1;
    localparam int kindStore = 2;
    localparam int cyclesPerInstr = 50;

    wire Clock;
    wire rstN;
    wire memReq;
    wire memWe;
    wire cpuPkg::addrT memAddr;
    wire cpuPkg::wordT memWdata;
    logic memAck = 1'b0;
    cpuPkg::wordT memRdata = '0;

    cpuPkg::wordT mem [memWords];
    cpuPkg::wordT refMem [memWords];
    cpuPkg::wordT refRegs [32];
    cpuPkg::addrT refPc;
    cpuPkg::addrT haltPc;
    string testOf [memWords];
    string curTest;
    int progLen;
    integer seed = 32'ha6dab853;

    // expected bus transfers, in order
    int expKind [$];
    cpuPkg::addrT expAddr [$];
    cpuPkg::wordT expData [$];
    string expTest [$];

    int ackDelay;
    int checkedCount;
    int stepCount;
    int haltFetches;
    int cycleLimit;
    int cycles;
    bit ackSeen;
    bit allChecked;

    clockGen clk0 (
        .Clock(Clock),
        .rstN(rstN)
    );

    riscCore dut0 (
        .Clock(Clock),
        .rstN(rstN),
        .memReq(memReq),
        .memWe(memWe),
        .memAddr(memAddr),
        .memWdata(memWdata),
        .memAck(memAck),
        .memRdata(memRdata)
    );

    // ====================
    // instruction encoding
    // ====================
    function automatic cpuPkg::instrT encR(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], cpuPkg::opOp};
    endfunction

    function automatic cpuPkg::instrT encI(int imm, int rs1, int f3, int rd,
                                           cpuPkg::opcodeT op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic cpuPkg::instrT encS(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], cpuPkg::opStore};
    endfunction

    function automatic cpuPkg::instrT encB(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                cpuPkg::opBranch};
    endfunction

    function automatic cpuPkg::instrT encJ(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], cpuPkg::opJal};
    endfunction

    function automatic void putInstr(cpuPkg::instrT w);
        mem[progLen] = w;
        testOf[progLen] = curTest;
        progLen++;
    endfunction

    // x1 points at random data, x2 at the store area
    task automatic buildProgram();
        int shiftAmt [3];
        shiftAmt = '{0, 1, 31};
        progLen = 0;
        curTest = "setup";
        putInstr(encI(512, 0, 0, 1, cpuPkg::opOpImm));
        putInstr(encI(768, 0, 0, 2, cpuPkg::opOpImm));
        putInstr(encI(0, 1, 2, 3, cpuPkg::opLoad));
        putInstr(encI(4, 1, 2, 4, cpuPkg::opLoad));
        curTest = "arith";
        putInstr(encR(0, 4, 3, 0, 5));
        putInstr(encS(0, 5, 2));
        putInstr(encR(32, 4, 3, 0, 5));
        putInstr(encS(4, 5, 2));
        putInstr(encR(0, 4, 3, 7, 5));
        putInstr(encS(8, 5, 2));
        putInstr(encR(0, 4, 3, 6, 5));
        putInstr(encS(12, 5, 2));
        putInstr(encR(0, 4, 3, 4, 5));
        putInstr(encS(16, 5, 2));
        putInstr(encI(-1234, 3, 0, 5, cpuPkg::opOpImm));
        putInstr(encS(20, 5, 2));
        curTest = "zeroReg";
        putInstr(encI(5, 3, 0, 0, cpuPkg::opOpImm));
        putInstr(encR(0, 4, 3, 0, 0));
        putInstr(encS(24, 0, 2));
        curTest = "shift";
        for (int k = 0; k < 3; k++) begin
            putInstr(encI(shiftAmt[k], 0, 0, 6, cpuPkg::opOpImm));
            putInstr(encR(0, 6, 3, 1, 7));
            putInstr(encS(28 + 8 * k, 7, 2));
            putInstr(encR(0, 6, 3, 5, 7));
            putInstr(encS(32 + 8 * k, 7, 2));
        end
        // copy loop over four words, BNE back to its top
        curTest = "copy";
        putInstr(encI(16, 1, 0, 10, cpuPkg::opOpImm));
        putInstr(encI(68, 2, 0, 11, cpuPkg::opOpImm));
        putInstr(encI(4, 0, 0, 12, cpuPkg::opOpImm));
        putInstr(encI(0, 10, 2, 13, cpuPkg::opLoad));
        putInstr(encS(0, 13, 11));
        putInstr(encI(4, 10, 0, 10, cpuPkg::opOpImm));
        putInstr(encI(4, 11, 0, 11, cpuPkg::opOpImm));
        putInstr(encI(-1, 12, 0, 12, cpuPkg::opOpImm));
        putInstr(encB(-20, 0, 12, 1));
        curTest = "branch";
        putInstr(encB(8, 3, 3, 0));
        putInstr(encI(99, 0, 0, 14, cpuPkg::opOpImm));
        putInstr(encB(8, 4, 3, 0));
        putInstr(encI(7, 0, 0, 14, cpuPkg::opOpImm));
        putInstr(encB(8, 3, 3, 1));
        putInstr(encS(84, 14, 2));
        curTest = "jal";
        putInstr(encJ(8, 15));
        putInstr(encI(1, 0, 0, 15, cpuPkg::opOpImm));
        putInstr(encS(88, 15, 2));
        curTest = "halt";
        haltPc = progLen * 4;
        putInstr(encJ(0, 0));
    endtask

    // ====================
    // reference model
    // ====================
    function automatic void expectTransfer(int kind, cpuPkg::addrT addr,
                                           cpuPkg::wordT data, string name);
        expKind.push_back(kind);
        expAddr.push_back(addr);
        expData.push_back(data);
        expTest.push_back(name);
    endfunction

    function automatic void refStep();
        cpuPkg::instrT ins;
        cpuPkg::wordT a;
        cpuPkg::wordT b;
        cpuPkg::wordT res;
        cpuPkg::wordT immI;
        cpuPkg::wordT immS;
        cpuPkg::wordT immB;
        cpuPkg::wordT immJ;
        cpuPkg::addrT addr;
        cpuPkg::addrT nextPc;
        string name;
        bit writeRd;
        ins = refMem[refPc[9:2]];
        name = testOf[refPc[9:2]];
        expectTransfer(kindFetch, refPc, ins, name);
        a = refRegs[ins[19:15]];
        b = refRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        res = '0;
        writeRd = 1'b0;
        nextPc = refPc + 32'd4;
        case (ins[6:0])
            cpuPkg::opOpImm: begin
                res = a + immI;
                writeRd = 1'b1;
            end
            cpuPkg::opOp: begin
                case (ins[14:12])
                    3'b000:  res = ins[30] ? a - b : a + b;
                    3'b001:  res = a << b[4:0];
                    3'b100:  res = a ^ b;
                    3'b101:  res = a >> b[4:0];
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
                writeRd = 1'b1;
            end
            cpuPkg::opLoad: begin
                addr = a + immI;
                res = refMem[addr[9:2]];
                expectTransfer(kindLoad, addr, res, name);
                writeRd = 1'b1;
            end
            cpuPkg::opStore: begin
                addr = a + immS;
                refMem[addr[9:2]] = b;
                expectTransfer(kindStore, addr, b, name);
            end
            cpuPkg::opBranch: begin
                // funct3 bit 0 selects BNE
                if ((a == b) != ins[12]) begin
                    nextPc = refPc + immB;
                end
            end
            default: begin
                res = refPc + 32'd4;
                writeRd = 1'b1;
                nextPc = refPc + immJ;
            end
        endcase
        if (writeRd && ins[11:7] != 5'd0) begin
            refRegs[ins[11:7]] = res;
        end
        refPc = nextPc;
    endfunction

    // ====================
    // compare tasks
    // ====================
    task automatic failRun();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic checkAddr(string name, cpuPkg::addrT expected, cpuPkg::addrT actual);
        if (actual !== expected) begin
            $display("error %s: address expected %h, actual %h", name, expected, actual);
            failRun();
        end
    endtask

    task automatic checkWord(string name, cpuPkg::wordT expected, cpuPkg::wordT actual);
        if (actual !== expected) begin
            $display("error %s: data expected %h, actual %h", name, expected, actual);
            failRun();
        end
    endtask

    task automatic checkInstr(string name, cpuPkg::instrT expected, cpuPkg::instrT actual);
        if (actual !== expected) begin
            $display("error %s: instruction expected %h, actual %h", name, expected, actual);
            failRun();
        end
    endtask

    task automatic compareTransfer();
        int k;
        bit expWe;
        k = checkedCount;
        expWe = expKind[k] == kindStore;
        if (memWe !== expWe) begin
            $display("error %s: write enable expected %b, actual %b", expTest[k], expWe, memWe);
            failRun();
        end
        checkAddr(expTest[k], expAddr[k], memAddr);
        if (expKind[k] == kindFetch) begin
            checkInstr(expTest[k], expData[k], memRdata);
        end else if (expKind[k] == kindLoad) begin
            checkWord(expTest[k], expData[k], memRdata);
        end else begin
            checkWord(expTest[k], expData[k], memWdata);
        end
        checkedCount++;
        if (checkedCount == expKind.size()) begin
            allChecked = 1'b1;
        end
    endtask

    // ====================
    // memory responder
    // ====================
    // random wait of 0 to 3 cycles before each ack edge
    always @(posedge Clock) begin
        if (!rstN) begin
            memAck <= 1'b0;
            ackDelay = 0;
        end else if (memAck == memReq) begin
            ackDelay = $random(seed) & 3;
        end else if (ackDelay != 0) begin
            ackDelay = ackDelay - 1;
        end else if (memReq) begin
            if (memWe) begin
                mem[memAddr[9:2]] = memWdata;
            end
            memRdata <= mem[memAddr[9:2]];
            memAck <= 1'b1;
        end else begin
            memAck <= 1'b0;
        end
    end

    // bus is sampled as memAck rises, while address and data are held
    always @(posedge Clock) begin
        if (!rstN) begin
            if (memReq === 1'b1) begin
                $display("memReq was raised while reset was held");
                failRun();
            end
        end else if (memAck && !ackSeen && !allChecked) begin
            compareTransfer();
        end
        ackSeen = memAck;
    end

    initial begin
        for (int i = 0; i < memWords; i++) begin
            mem[i] = $random(seed);
        end
        buildProgram();
        refMem = mem;
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        refPc = cpuPkg::resetPc;
        haltFetches = 0;
        stepCount = 0;
        // run until the final JAL has been fetched twice
        while (haltFetches < 2 && stepCount < 1000) begin
            if (refPc == haltPc) begin
                haltFetches++;
            end
            refStep();
            stepCount++;
        end
        cycleLimit = stepCount * cyclesPerInstr + 20;
        cycles = 0;
        while (!allChecked && cycles < cycleLimit) begin
            @(posedge Clock);
            cycles++;
        end
        if (allChecked) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("timeout: the core did not finish the program in %0d cycles",
                     cycleLimit);
            failRun();
        end
    end

endmodule

`default_nettype wire
